//--- files.f
verilog/decode_pkg.sv
verilog/inst_class.sv
verilog/op_decode.sv
verilog/operand_forward.sv
verilog/id_stage_reg.sv
verilog/decode_stage.sv
tb/tb_decode_stage.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_decode_stage \
  -o sim_decode_stage || exit 1
./obj_dir/sim_decode_stage | tee /dev/stderr | grep -q "test passed" && exit 0 || exit 1

//--- tb/tb_decode_stage.sv
`timescale 1ns/1ns

module tb_decode_stage
  import decode_pkg::*;
();

  typedef struct packed {
    logic [XLEN-1:0]       addr;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       d1;
    logic [XLEN-1:0]       d2;
    logic [XLEN-1:0]       imm;
    logic [4:0]            alu;
    logic [3:0]            mem;
    logic [3:0]            exc;
    logic [TRAP_W-1:0]     trap;
  } exp_t;

  logic                  clk;
  logic                  rst_i;
  logic                  in_valid_i;
  logic                  in_ready_o;
  logic [XLEN-1:0]       inst_addr_i;
  logic [INST_W-1:0]     inst_i;
  logic [TRAP_W-1:0]     trap_bus_i;
  logic [XLEN-1:0]       rs1_data_i;
  logic [XLEN-1:0]       rs2_data_i;
  logic [REG_ADDR_W-1:0] ex_rd_addr_i;
  logic [XLEN-1:0]       ex_rd_data_i;
  logic [REG_ADDR_W-1:0] mem_rd_addr_i;
  logic [XLEN-1:0]       mem_rd_data_i;
  logic                  out_valid_o;
  logic                  out_ready_i;
  logic [XLEN-1:0]       inst_addr_o;
  logic [REG_ADDR_W-1:0] rs1_idx_o;
  logic [REG_ADDR_W-1:0] rs2_idx_o;
  logic [REG_ADDR_W-1:0] rd_idx_o;
  logic [XLEN-1:0]       rs1_data_o;
  logic [XLEN-1:0]       rs2_data_o;
  logic [XLEN-1:0]       imm_o;
  alu_op_t               alu_op_o;
  mem_op_t               mem_op_o;
  exc_op_t               exc_op_o;
  logic [TRAP_W-1:0]     trap_bus_o;

  logic [31:0] lfsr = 32'h3922;
  exp_t        exp_q[$];
  int          errors = 0;
  int          checks = 0;
  int          pops = 0;
  logic        bp_mode = 1'b0;

  decode_stage decode_stage_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand_bits(32);
    lo = rand_bits(32);
    return {hi, lo};
  endfunction

  function automatic logic [XLEN-1:0] pick_operand(input logic [4:0] idx,
      input logic [XLEN-1:0] gpr, input logic [4:0] ex_a, input logic [XLEN-1:0] ex_d,
      input logic [4:0] mem_a, input logic [XLEN-1:0] mem_d);
    if (idx != 5'd0 && idx == ex_a) return ex_d;
    if (idx != 5'd0 && idx == mem_a) return mem_d;
    return gpr;
  endfunction

  // reference decode written from the rv64i encoding tables
  function automatic exp_t ref_model(input logic [31:0] inst, input logic [15:0] trap,
      input logic [63:0] addr, input logic [63:0] d1, input logic [63:0] d2);
    exp_t        e;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        use1, use2, used, bad, ec, eb, mr, f7_ok;
    logic [63:0] imm_i;
    opc   = inst[6:0];
    f3    = inst[14:12];
    f7    = inst[31:25];
    imm_i = {{52{inst[31]}}, inst[31:20]};
    f7_ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
    e = '0;
    e.addr = addr;
    e.alu = ALU_NONE;
    e.mem = MEM_NONE;
    e.exc = EXC_NONE;
    {use1, use2, used, bad, ec, eb, mr} = '0;
    case (opc)
      OPC_LUI, OPC_AUIPC: begin
        used  = 1'b1;
        e.imm = {{32{inst[31]}}, inst[31:12], 12'b0};
        e.alu = ALU_ADD;
        e.exc = (opc == OPC_LUI) ? EXC_LUI : EXC_AUIPC;
      end
      OPC_JAL: begin
        used  = 1'b1;
        e.imm = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        e.alu = ALU_ADD;
        e.exc = EXC_JAL;
      end
      OPC_JALR: begin
        {use1, used} = 2'b11;
        e.imm = imm_i;
        e.alu = ALU_ADD;
        e.exc = EXC_JALR;
        bad   = (f3 != 3'd0);
      end
      OPC_BRANCH: begin
        {use1, use2} = 2'b11;
        e.imm = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        e.exc = EXC_BRANCH;
        case (f3)
          3'd0: e.alu = ALU_BEQ;
          3'd1: e.alu = ALU_BNE;
          3'd4: e.alu = ALU_BLT;
          3'd5: e.alu = ALU_BGE;
          3'd6: e.alu = ALU_BLTU;
          3'd7: e.alu = ALU_BGEU;
          default: bad = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        {use1, used} = 2'b11;
        e.imm = imm_i;
        e.alu = ALU_ADD;
        e.exc = EXC_LOAD;
        case (f3)
          3'd0: e.mem = MEM_LB;
          3'd1: e.mem = MEM_LH;
          3'd2: e.mem = MEM_LW;
          3'd3: e.mem = MEM_LD;
          3'd4: e.mem = MEM_LBU;
          3'd5: e.mem = MEM_LHU;
          3'd6: e.mem = MEM_LWU;
          default: bad = 1'b1;
        endcase
      end
      OPC_STORE: begin
        {use1, use2} = 2'b11;
        e.imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
        e.alu = ALU_ADD;
        e.exc = EXC_STORE;
        case (f3)
          3'd0: e.mem = MEM_SB;
          3'd1: e.mem = MEM_SH;
          3'd2: e.mem = MEM_SW;
          3'd3: e.mem = MEM_SD;
          default: bad = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        {use1, used} = 2'b11;
        e.imm = imm_i;
        e.exc = EXC_OP_IMM;
        case (f3)
          3'd0: e.alu = ALU_ADD;
          3'd2: e.alu = ALU_SLT;
          3'd3: e.alu = ALU_SLTU;
          3'd4: e.alu = ALU_XOR;
          3'd6: e.alu = ALU_OR;
          3'd7: e.alu = ALU_AND;
          3'd1: begin
            e.alu = ALU_SLL;
            bad   = (inst[31:26] != 6'h00);
          end
          default: begin
            e.alu = inst[30] ? ALU_SRA : ALU_SRL;
            bad   = !(inst[31:26] == 6'h00 || inst[31:26] == 6'h10);
          end
        endcase
      end
      OPC_OP: begin
        {use1, use2, used} = 3'b111;
        e.exc = EXC_OP;
        bad   = !f7_ok;
        case (f3)
          3'd0: e.alu = f7[5] ? ALU_SUB : ALU_ADD;
          3'd1: e.alu = ALU_SLL;
          3'd2: e.alu = ALU_SLT;
          3'd3: e.alu = ALU_SLTU;
          3'd4: e.alu = ALU_XOR;
          3'd5: e.alu = f7[5] ? ALU_SRA : ALU_SRL;
          3'd6: e.alu = ALU_OR;
          default: e.alu = ALU_AND;
        endcase
      end
      OPC_OP_IMM_32: begin
        {use1, used} = 2'b11;
        e.imm = imm_i;
        e.exc = EXC_OP_IMM_32;
        case (f3)
          3'd0: e.alu = ALU_ADD;
          3'd1: begin
            e.alu = ALU_SLLW;
            bad   = (f7 != 7'h00);
          end
          3'd5: begin
            e.alu = f7[5] ? ALU_SRAW : ALU_SRLW;
            bad   = !(f7 == 7'h00 || f7 == 7'h20);
          end
          default: bad = 1'b1;
        endcase
      end
      OPC_OP_32: begin
        {use1, use2, used} = 3'b111;
        e.exc = EXC_OP_32;
        bad   = !f7_ok;
        case (f3)
          3'd0: e.alu = f7[5] ? ALU_SUB : ALU_ADD;
          3'd1: e.alu = ALU_SLLW;
          3'd5: e.alu = f7[5] ? ALU_SRAW : ALU_SRLW;
          default: bad = 1'b1;
        endcase
      end
      OPC_SYSTEM: begin
        {use1, used} = 2'b11;
        e.imm = imm_i;
        ec    = (f3 == 3'd0) && (inst[31:20] == 12'h000);
        eb    = (f3 == 3'd0) && (inst[31:20] == 12'h001);
        mr    = (f3 == 3'd0) && (inst[31:20] == 12'h302);
        e.exc = eb ? EXC_EBREAK : EXC_SYSTEM;
        bad   = !(ec || eb || mr);
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      e.alu = ALU_NONE;
      e.mem = MEM_NONE;
      e.exc = EXC_NONE;
    end
    e.rs1 = use1 ? inst[19:15] : 5'd0;
    e.rs2 = use2 ? inst[24:20] : 5'd0;
    e.rd  = used ? inst[11:7] : 5'd0;
    e.d1  = pick_operand(e.rs1, d1, ex_rd_addr_i, ex_rd_data_i, mem_rd_addr_i, mem_rd_data_i);
    e.d2  = pick_operand(e.rs2, d2, ex_rd_addr_i, ex_rd_data_i, mem_rd_addr_i, mem_rd_data_i);
    e.trap = trap;
    e.trap[TRAP_MRET]    = mr;
    e.trap[TRAP_EBREAK]  = eb;
    e.trap[TRAP_ECALL_M] = ec;
    e.trap[TRAP_ILLEGAL] = bad;
    return e;
  endfunction

  // small register numbers so that bypass and load-use collisions are common
  function automatic logic [31:0] gen_inst();
    logic [31:0] sel;
    logic [31:0] r;
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [11:0] up;
    sel = rand_bits(4);
    case (sel)
      0: opc = OPC_LUI;
      1: opc = OPC_AUIPC;
      2: opc = OPC_JAL;
      3: opc = OPC_JALR;
      4: opc = OPC_BRANCH;
      5, 13: opc = OPC_LOAD;
      6: opc = OPC_STORE;
      7, 14: opc = OPC_OP_IMM;
      8, 9: opc = OPC_OP;
      10: opc = OPC_OP_IMM_32;
      11: opc = OPC_OP_32;
      12: opc = OPC_SYSTEM;
      default: opc = 7'(rand_bits(7));
    endcase
    r = rand_bits(2);
    f7 = (r < 2) ? 7'h00 : (r == 2) ? 7'h20 : 7'(rand_bits(7));
    if (opc == OPC_SYSTEM) begin
      r = rand_bits(2);
      up = (r == 0) ? 12'h000 : (r == 1) ? 12'h001 : (r == 2) ? 12'h302 : 12'(rand_bits(12));
      r = rand_bits(1);
      return {up, 5'd0, (r[0] ? 3'd0 : 3'(rand_bits(3))), 5'd0, opc};
    end
    return {f7, 5'(rand_bits(3)), 5'(rand_bits(3)), 3'(rand_bits(3)), 5'(rand_bits(3)), opc};
  endfunction

  task automatic check_val(input string name, input logic [63:0] got,
      input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // everything is sampled on the falling edge, between driving edges
  always @(negedge clk) begin : monitor
    exp_t cur;
    logic exp_ready;
    if (!rst_i) begin
      check_val("out_valid_o", 64'(out_valid_o), 64'(exp_q.size() != 0));
      if (out_valid_o && exp_q.size() != 0) begin
        check_val("inst_addr_o", inst_addr_o, exp_q[0].addr);
        check_val("rs1_idx_o", 64'(rs1_idx_o), 64'(exp_q[0].rs1));
        check_val("rs2_idx_o", 64'(rs2_idx_o), 64'(exp_q[0].rs2));
        check_val("rd_idx_o", 64'(rd_idx_o), 64'(exp_q[0].rd));
        check_val("rs1_data_o", rs1_data_o, exp_q[0].d1);
        check_val("rs2_data_o", rs2_data_o, exp_q[0].d2);
        check_val("imm_o", imm_o, exp_q[0].imm);
        check_val("alu_op_o", 64'(alu_op_o), 64'(exp_q[0].alu));
        check_val("mem_op_o", 64'(mem_op_o), 64'(exp_q[0].mem));
        check_val("exc_op_o", 64'(exc_op_o), 64'(exp_q[0].exc));
        check_val("trap_bus_o", 64'(trap_bus_o), 64'(exp_q[0].trap));
      end
      cur = ref_model(inst_i, trap_bus_i, inst_addr_i, rs1_data_i, rs2_data_i);
      exp_ready = !out_valid_o || out_ready_i;
      if (out_valid_o && exp_q.size() != 0 && exp_q[0].exc == EXC_LOAD) begin
        if ((cur.rs1 != 5'd0 && cur.rs1 == exp_q[0].rd) ||
            (cur.rs2 != 5'd0 && cur.rs2 == exp_q[0].rd)) begin
          exp_ready = 1'b0;
        end
      end
      check_val("in_ready_o", 64'(in_ready_o), 64'(exp_ready));
      if (out_valid_o && out_ready_i && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
        pops++;
      end
      if (in_valid_i && in_ready_o) begin
        exp_q.push_back(cur);
      end
    end
  end

  // next ready value is picked between driving edges
  initial begin : ready_driver
    logic nxt;
    forever begin
      @(negedge clk);
      nxt = bp_mode ? (rand_bits(2) != 0) : 1'b1;
      @(posedge clk);
      out_ready_i <= nxt;
    end
  end

  // execute and memory bypass, memory address sometimes copies the execute one
  task automatic drive_bypass();
    logic [REG_ADDR_W-1:0] ex_a;
    ex_a = 5'(rand_bits(3));
    ex_rd_addr_i  <= ex_a;
    ex_rd_data_i  <= rand64();
    mem_rd_data_i <= rand64();
    if (rand_bits(1) != 0) begin
      mem_rd_addr_i <= ex_a;
    end else begin
      mem_rd_addr_i <= 5'(rand_bits(3));
    end
  endtask

  task automatic send_inst(input logic [31:0] inst, output int stalls);
    int t;
    stalls = 0;
    t = 0;
    @(posedge clk);
    in_valid_i    <= 1'b1;
    inst_i        <= inst;
    inst_addr_i   <= rand64();
    rs1_data_i    <= rand64();
    rs2_data_i    <= rand64();
    trap_bus_i    <= 16'(rand_bits(16));
    drive_bypass();
    @(negedge clk);
    while (!in_ready_o && t < 100) begin
      stalls++;
      t++;
      // bypass moves on while the instruction waits
      @(posedge clk);
      drive_bypass();
      @(negedge clk);
    end
    if (!in_ready_o) begin
      $display("timeout: instruction %h was never accepted", inst);
      errors++;
    end
  endtask

  task automatic drain(input string name);
    int t;
    t = 0;
    @(posedge clk);
    in_valid_i <= 1'b0;
    bp_mode = 1'b0;
    @(posedge clk);
    while (exp_q.size() != 0 && t < 100) begin
      t++;
      @(posedge clk);
    end
    if (exp_q.size() != 0) begin
      $display("timeout: outputs of test %s never drained", name);
      errors++;
    end
    $display("test %s finished, %0d errors so far", name, errors);
  endtask

  task automatic expect_stalls(input logic [31:0] first, input logic [31:0] second,
      input int exp);
    int s;
    send_inst(first, s);
    send_inst(second, s);
    checks++;
    assert (s == exp) else begin
      $display("error at %0t: stall cycles is %0d, expected %0d", $time, s, exp);
      errors++;
    end
  endtask

  initial begin : watchdog
    #20_000_000;
    $display("simulation did not finish in time");
    $display("test failed");
    $finish;
  end

  initial begin : main
    int s;
    rst_i = 1'b1;
    in_valid_i = 1'b0;
    inst_addr_i = '0;
    inst_i = '0;
    trap_bus_i = '0;
    rs1_data_i = '0;
    rs2_data_i = '0;
    ex_rd_addr_i = '0;
    ex_rd_data_i = '0;
    mem_rd_addr_i = '0;
    mem_rd_data_i = '0;
    out_ready_i = 1'b1;
    repeat (2) @(posedge clk);
    rst_i <= 1'b0;
    @(negedge clk);
    check_val("out_valid_o after reset", 64'(out_valid_o), 64'd0);
    check_val("in_ready_o after reset", 64'(in_ready_o), 64'd1);
    for (int i = 0; i < 20; i++) send_inst(32'h00a30313 + (i << 20), s);
    drain("reset_latency");

    for (int i = 0; i < 400; i++) send_inst(gen_inst(), s);
    drain("random_decode_forward");

    // ld x5 then readers of x5 through rs1 and rs2
    expect_stalls(32'h0103b283, {7'h0, 5'd2, 5'd5, 3'd0, 5'd6, OPC_OP}, 1);
    expect_stalls(32'h0103b283, {7'h0, 5'd5, 5'd3, 3'd0, 5'd6, OPC_OP}, 1);
    // x0 and unused index fields do not stall
    expect_stalls(32'h0103b003, {7'h0, 5'd0, 5'd0, 3'd0, 5'd6, OPC_OP}, 0);
    expect_stalls(32'h0103b283, {12'h000, 5'd5, 3'd0, 5'd7, OPC_LUI}, 0);
    expect_stalls(32'h0103b283, {7'h0, 5'd5, 5'd1, 3'd0, 5'd7, OPC_OP_IMM}, 0);
    drain("load_use");

    send_inst(32'h00000073, s);
    send_inst(32'h00100073, s);
    send_inst(32'h30200073, s);
    send_inst(32'h00000000, s);
    send_inst(32'h30001073, s);
    drain("traps");

    bp_mode = 1'b1;
    for (int i = 0; i < 300; i++) send_inst(gen_inst(), s);
    drain("back_pressure");

    $display("checks %0d, errors %0d, transfers %0d", checks, errors, pops);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- verilog/decode_pkg.sv
package decode_pkg;

  // data path and field widths
  localparam int XLEN       = 64;
  localparam int INST_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int TRAP_W     = 16;

  // trap bus bits owned by decode, the rest pass through
  localparam int TRAP_MRET    = 0;
  localparam int TRAP_EBREAK  = 1;
  localparam int TRAP_ECALL_M = 2;
  localparam int TRAP_ILLEGAL = 3;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_LOAD      = 7'b0000011;
  localparam logic [6:0] OPC_STORE     = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

  typedef enum logic [3:0] {
    CLS_LOAD, CLS_STORE, CLS_BRANCH, CLS_JALR, CLS_JAL,
    CLS_OP_IMM, CLS_OP, CLS_OP_IMM_32, CLS_OP_32,
    CLS_AUIPC, CLS_LUI, CLS_SYSTEM, CLS_NONE
  } inst_class_t;

  // execute unit operation, one per class
  typedef enum logic [3:0] {
    EXC_LOAD, EXC_STORE, EXC_BRANCH, EXC_JALR, EXC_JAL,
    EXC_OP_IMM, EXC_OP, EXC_OP_IMM_32, EXC_OP_32,
    EXC_AUIPC, EXC_LUI, EXC_SYSTEM, EXC_EBREAK, EXC_NONE
  } exc_op_t;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLLW, ALU_SRLW, ALU_SRAW,
    ALU_SLT, ALU_SLTU,
    ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
    ALU_NONE
  } alu_op_t;

  typedef enum logic [3:0] {
    MEM_NONE,
    MEM_LB, MEM_LH, MEM_LW, MEM_LD,
    MEM_LBU, MEM_LHU, MEM_LWU,
    MEM_SB, MEM_SH, MEM_SW, MEM_SD
  } mem_op_t;

endpackage

//--- verilog/decode_stage.sv
`timescale 1ns/1ns

module decode_stage
  import decode_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic [XLEN-1:0]       inst_addr_i,
  input  logic [INST_W-1:0]     inst_i,
  input  logic [TRAP_W-1:0]     trap_bus_i,
  input  logic [XLEN-1:0]       rs1_data_i,
  input  logic [XLEN-1:0]       rs2_data_i,
  input  logic [REG_ADDR_W-1:0] ex_rd_addr_i,
  input  logic [XLEN-1:0]       ex_rd_data_i,
  input  logic [REG_ADDR_W-1:0] mem_rd_addr_i,
  input  logic [XLEN-1:0]       mem_rd_data_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic [XLEN-1:0]       inst_addr_o,
  output logic [REG_ADDR_W-1:0] rs1_idx_o,
  output logic [REG_ADDR_W-1:0] rs2_idx_o,
  output logic [REG_ADDR_W-1:0] rd_idx_o,
  output logic [XLEN-1:0]       rs1_data_o,
  output logic [XLEN-1:0]       rs2_data_o,
  output logic [XLEN-1:0]       imm_o,
  output alu_op_t               alu_op_o,
  output mem_op_t               mem_op_o,
  output exc_op_t               exc_op_o,
  output logic [TRAP_W-1:0]     trap_bus_o
);

  inst_class_t           dec_class;
  logic [REG_ADDR_W-1:0] dec_rs1_idx, dec_rs2_idx, dec_rd_idx;
  logic [XLEN-1:0]       dec_imm;
  alu_op_t               dec_alu_op;
  mem_op_t               dec_mem_op;
  exc_op_t               dec_exc_op;
  logic [TRAP_W-1:0]     dec_trap_bus;
  logic [XLEN-1:0]       fwd_rs1_data, fwd_rs2_data;
  logic                  rs1_hit, rs2_hit;

  inst_class inst_class_i (
    .inst_i    (inst_i),
    .class_o   (dec_class),
    .rs1_idx_o (dec_rs1_idx),
    .rs2_idx_o (dec_rs2_idx),
    .rd_idx_o  (dec_rd_idx),
    .imm_o     (dec_imm)
  );

  op_decode op_decode_i (
    .inst_i     (inst_i),
    .class_i    (dec_class),
    .trap_bus_i (trap_bus_i),
    .alu_op_o   (dec_alu_op),
    .mem_op_o   (dec_mem_op),
    .exc_op_o   (dec_exc_op),
    .trap_bus_o (dec_trap_bus)
  );

  // load-use stall is decided against the held instruction, not the bypass
  operand_forward rs1_forward_i (
    .idx_i         (dec_rs1_idx),
    .gpr_data_i    (rs1_data_i),
    .ex_rd_addr_i  (ex_rd_addr_i),
    .mem_rd_addr_i (mem_rd_addr_i),
    .ex_rd_data_i  (ex_rd_data_i),
    .mem_rd_data_i (mem_rd_data_i),
    .data_o        (fwd_rs1_data),
    .ex_match_o    ()
  );

  operand_forward rs2_forward_i (
    .idx_i         (dec_rs2_idx),
    .gpr_data_i    (rs2_data_i),
    .ex_rd_addr_i  (ex_rd_addr_i),
    .mem_rd_addr_i (mem_rd_addr_i),
    .ex_rd_data_i  (ex_rd_data_i),
    .mem_rd_data_i (mem_rd_data_i),
    .data_o        (fwd_rs2_data),
    .ex_match_o    ()
  );

  // gated indexes are zero when unused, so x0 and unused never hit
  assign rs1_hit = (dec_rs1_idx != '0) && (dec_rs1_idx == rd_idx_o);
  assign rs2_hit = (dec_rs2_idx != '0) && (dec_rs2_idx == rd_idx_o);

  id_stage_reg id_stage_reg_i (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .inst_addr_i (inst_addr_i),
    .rs1_idx_i   (dec_rs1_idx),
    .rs2_idx_i   (dec_rs2_idx),
    .rd_idx_i    (dec_rd_idx),
    .rs1_data_i  (fwd_rs1_data),
    .rs2_data_i  (fwd_rs2_data),
    .imm_i       (dec_imm),
    .alu_op_i    (dec_alu_op),
    .mem_op_i    (dec_mem_op),
    .exc_op_i    (dec_exc_op),
    .trap_bus_i  (dec_trap_bus),
    .rs1_hit_i   (rs1_hit),
    .rs2_hit_i   (rs2_hit),
    .inst_addr_o (inst_addr_o),
    .rs1_idx_o   (rs1_idx_o),
    .rs2_idx_o   (rs2_idx_o),
    .rd_idx_o    (rd_idx_o),
    .rs1_data_o  (rs1_data_o),
    .rs2_data_o  (rs2_data_o),
    .imm_o       (imm_o),
    .alu_op_o    (alu_op_o),
    .mem_op_o    (mem_op_o),
    .exc_op_o    (exc_op_o),
    .trap_bus_o  (trap_bus_o)
  );

endmodule

//--- verilog/id_stage_reg.sv
`timescale 1ns/1ns

module id_stage_reg
  import decode_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  input  logic [XLEN-1:0]       inst_addr_i,
  input  logic [REG_ADDR_W-1:0] rs1_idx_i,
  input  logic [REG_ADDR_W-1:0] rs2_idx_i,
  input  logic [REG_ADDR_W-1:0] rd_idx_i,
  input  logic [XLEN-1:0]       rs1_data_i,
  input  logic [XLEN-1:0]       rs2_data_i,
  input  logic [XLEN-1:0]       imm_i,
  input  alu_op_t               alu_op_i,
  input  mem_op_t               mem_op_i,
  input  exc_op_t               exc_op_i,
  input  logic [TRAP_W-1:0]     trap_bus_i,
  input  logic                  rs1_hit_i,
  input  logic                  rs2_hit_i,
  output logic [XLEN-1:0]       inst_addr_o,
  output logic [REG_ADDR_W-1:0] rs1_idx_o,
  output logic [REG_ADDR_W-1:0] rs2_idx_o,
  output logic [REG_ADDR_W-1:0] rd_idx_o,
  output logic [XLEN-1:0]       rs1_data_o,
  output logic [XLEN-1:0]       rs2_data_o,
  output logic [XLEN-1:0]       imm_o,
  output alu_op_t               alu_op_o,
  output mem_op_t               mem_op_o,
  output exc_op_t               exc_op_o,
  output logic [TRAP_W-1:0]     trap_bus_o
);

  logic load_en;
  logic held_load;
  logic stall;
  logic accept;

  // register may change when empty or when downstream takes it
  assign load_en   = !out_valid_o || out_ready_i;
  assign held_load = out_valid_o && (exc_op_o == EXC_LOAD);
  // load data is not ready for a consumer right behind it
  assign stall      = held_load && (rs1_hit_i || rs2_hit_i);
  assign in_ready_o = load_en && !stall;
  assign accept     = in_valid_i && in_ready_o;

  // a stalled cycle with out_ready_i high drains the load and leaves a bubble
  always_ff @(posedge clk) begin
    if (rst_i) begin
      out_valid_o <= 1'b0;
    end else if (load_en) begin
      out_valid_o <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst_addr_o <= inst_addr_i;
      rs1_idx_o   <= rs1_idx_i;
      rs2_idx_o   <= rs2_idx_i;
      rd_idx_o    <= rd_idx_i;
      rs1_data_o  <= rs1_data_i;
      rs2_data_o  <= rs2_data_i;
      imm_o       <= imm_i;
      alu_op_o    <= alu_op_i;
      mem_op_o    <= mem_op_i;
      exc_op_o    <= exc_op_i;
      trap_bus_o  <= trap_bus_i;
    end
  end

endmodule

//--- verilog/inst_class.sv
`timescale 1ns/1ns

module inst_class
  import decode_pkg::*;
(
  input  logic [INST_W-1:0]     inst_i,
  output inst_class_t           class_o,
  output logic [REG_ADDR_W-1:0] rs1_idx_o,
  output logic [REG_ADDR_W-1:0] rs2_idx_o,
  output logic [REG_ADDR_W-1:0] rd_idx_o,
  output logic [XLEN-1:0]       imm_o
);

  logic            fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  always_comb begin
    case (inst_i[6:0])
      OPC_LOAD:      class_o = CLS_LOAD;
      OPC_STORE:     class_o = CLS_STORE;
      OPC_BRANCH:    class_o = CLS_BRANCH;
      OPC_JALR:      class_o = CLS_JALR;
      OPC_JAL:       class_o = CLS_JAL;
      OPC_OP_IMM:    class_o = CLS_OP_IMM;
      OPC_OP:        class_o = CLS_OP;
      OPC_OP_IMM_32: class_o = CLS_OP_IMM_32;
      OPC_OP_32:     class_o = CLS_OP_32;
      OPC_AUIPC:     class_o = CLS_AUIPC;
      OPC_LUI:       class_o = CLS_LUI;
      OPC_SYSTEM:    class_o = CLS_SYSTEM;
      default:       class_o = CLS_NONE;
    endcase
  end

  // instruction format from the class
  assign fmt_r = (class_o == CLS_OP) || (class_o == CLS_OP_32);
  assign fmt_i = (class_o == CLS_LOAD) || (class_o == CLS_OP_IMM) ||
                 (class_o == CLS_OP_IMM_32) || (class_o == CLS_JALR) ||
                 (class_o == CLS_SYSTEM);
  assign fmt_s = (class_o == CLS_STORE);
  assign fmt_b = (class_o == CLS_BRANCH);
  assign fmt_u = (class_o == CLS_AUIPC) || (class_o == CLS_LUI);
  assign fmt_j = (class_o == CLS_JAL);

  // unused indexes read as x0
  assign rs1_idx_o = (fmt_r || fmt_i || fmt_s || fmt_b) ? inst_i[19:15] : '0;
  assign rs2_idx_o = (fmt_r || fmt_s || fmt_b) ? inst_i[24:20] : '0;
  assign rd_idx_o  = (fmt_r || fmt_i || fmt_u || fmt_j) ? inst_i[11:7] : '0;

  // sign extended immediates, sign always in inst[31]
  assign imm_i = {{(XLEN-11){inst_i[31]}}, inst_i[30:20]};
  assign imm_s = {{(XLEN-11){inst_i[31]}}, inst_i[30:25], inst_i[11:7]};
  assign imm_b = {{(XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {{(XLEN-31){inst_i[31]}}, inst_i[30:12], 12'b0};
  assign imm_j = {{(XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  always_comb begin
    if (fmt_i) begin
      imm_o = imm_i;
    end else if (fmt_s) begin
      imm_o = imm_s;
    end else if (fmt_b) begin
      imm_o = imm_b;
    end else if (fmt_u) begin
      imm_o = imm_u;
    end else if (fmt_j) begin
      imm_o = imm_j;
    end else begin
      // R format and unknown opcodes carry no immediate
      imm_o = '0;
    end
  end

endmodule

//--- verilog/op_decode.sv
`timescale 1ns/1ns

module op_decode
  import decode_pkg::*;
(
  input  logic [INST_W-1:0] inst_i,
  input  inst_class_t       class_i,
  input  logic [TRAP_W-1:0] trap_bus_i,
  output alu_op_t           alu_op_o,
  output mem_op_t           mem_op_o,
  output exc_op_t           exc_op_o,
  output logic [TRAP_W-1:0] trap_bus_o
);

  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] upper;
  logic        f7_zero, f7_alt, sh_zero, sh_alt, r_f7_ok;
  logic        illegal, is_ecall, is_ebreak, is_mret;

  assign funct3  = inst_i[14:12];
  assign funct7  = inst_i[31:25];
  assign upper   = inst_i[31:20];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);
  // rv64 shift amount takes funct7[0], only the upper six bits select the op
  assign sh_zero = (funct7[6:1] == 6'b000000);
  assign sh_alt  = (funct7[6:1] == 6'b010000);
  // sub and sra style encodings only exist for funct3 000 and 101
  assign r_f7_ok = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));

  always_comb begin
    alu_op_o  = ALU_NONE;
    mem_op_o  = MEM_NONE;
    exc_op_o  = EXC_NONE;
    illegal   = 1'b0;
    is_ecall  = 1'b0;
    is_ebreak = 1'b0;
    is_mret   = 1'b0;
    case (class_i)
      CLS_LUI: begin
        alu_op_o = ALU_ADD;
        exc_op_o = EXC_LUI;
      end
      CLS_AUIPC: begin
        alu_op_o = ALU_ADD;
        exc_op_o = EXC_AUIPC;
      end
      CLS_JAL: begin
        alu_op_o = ALU_ADD;
        exc_op_o = EXC_JAL;
      end
      CLS_JALR: begin
        alu_op_o = ALU_ADD;
        exc_op_o = EXC_JALR;
        illegal  = (funct3 != 3'b000);
      end
      CLS_BRANCH: begin
        exc_op_o = EXC_BRANCH;
        case (funct3)
          3'b000:  alu_op_o = ALU_BEQ;
          3'b001:  alu_op_o = ALU_BNE;
          3'b100:  alu_op_o = ALU_BLT;
          3'b101:  alu_op_o = ALU_BGE;
          3'b110:  alu_op_o = ALU_BLTU;
          3'b111:  alu_op_o = ALU_BGEU;
          default: illegal = 1'b1;
        endcase
      end
      CLS_LOAD: begin
        alu_op_o = ALU_ADD;
        exc_op_o = EXC_LOAD;
        case (funct3)
          3'b000:  mem_op_o = MEM_LB;
          3'b001:  mem_op_o = MEM_LH;
          3'b010:  mem_op_o = MEM_LW;
          3'b011:  mem_op_o = MEM_LD;
          3'b100:  mem_op_o = MEM_LBU;
          3'b101:  mem_op_o = MEM_LHU;
          3'b110:  mem_op_o = MEM_LWU;
          default: illegal = 1'b1;
        endcase
      end
      CLS_STORE: begin
        alu_op_o = ALU_ADD;
        exc_op_o = EXC_STORE;
        case (funct3)
          3'b000:  mem_op_o = MEM_SB;
          3'b001:  mem_op_o = MEM_SH;
          3'b010:  mem_op_o = MEM_SW;
          3'b011:  mem_op_o = MEM_SD;
          default: illegal = 1'b1;
        endcase
      end
      CLS_OP_IMM: begin
        exc_op_o = EXC_OP_IMM;
        case (funct3)
          3'b000: alu_op_o = ALU_ADD;
          3'b010: alu_op_o = ALU_SLT;
          3'b011: alu_op_o = ALU_SLTU;
          3'b100: alu_op_o = ALU_XOR;
          3'b110: alu_op_o = ALU_OR;
          3'b111: alu_op_o = ALU_AND;
          3'b001: begin
            alu_op_o = ALU_SLL;
            illegal  = !sh_zero;
          end
          default: begin
            alu_op_o = sh_alt ? ALU_SRA : ALU_SRL;
            illegal  = !(sh_zero || sh_alt);
          end
        endcase
      end
      CLS_OP: begin
        exc_op_o = EXC_OP;
        illegal  = !r_f7_ok;
        case (funct3)
          3'b000:  alu_op_o = f7_alt ? ALU_SUB : ALU_ADD;
          3'b001:  alu_op_o = ALU_SLL;
          3'b010:  alu_op_o = ALU_SLT;
          3'b011:  alu_op_o = ALU_SLTU;
          3'b100:  alu_op_o = ALU_XOR;
          3'b101:  alu_op_o = f7_alt ? ALU_SRA : ALU_SRL;
          3'b110:  alu_op_o = ALU_OR;
          default: alu_op_o = ALU_AND;
        endcase
      end
      CLS_OP_IMM_32: begin
        exc_op_o = EXC_OP_IMM_32;
        case (funct3)
          3'b000: alu_op_o = ALU_ADD;
          3'b001: begin
            alu_op_o = ALU_SLLW;
            illegal  = !f7_zero;
          end
          3'b101: begin
            alu_op_o = f7_alt ? ALU_SRAW : ALU_SRLW;
            illegal  = !(f7_zero || f7_alt);
          end
          default: illegal = 1'b1;
        endcase
      end
      CLS_OP_32: begin
        exc_op_o = EXC_OP_32;
        illegal  = !r_f7_ok;
        case (funct3)
          3'b000:  alu_op_o = f7_alt ? ALU_SUB : ALU_ADD;
          3'b001:  alu_op_o = ALU_SLLW;
          3'b101:  alu_op_o = f7_alt ? ALU_SRAW : ALU_SRLW;
          default: illegal = 1'b1;
        endcase
      end
      CLS_SYSTEM: begin
        is_ecall  = (funct3 == 3'b000) && (upper == 12'h000);
        is_ebreak = (funct3 == 3'b000) && (upper == 12'h001);
        is_mret   = (funct3 == 3'b000) && (upper == 12'h302);
        exc_op_o  = is_ebreak ? EXC_EBREAK : EXC_SYSTEM;
        // csr ops, fence style and wfi are not supported here
        illegal   = !(is_ecall || is_ebreak || is_mret);
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      alu_op_o = ALU_NONE;
      mem_op_o = MEM_NONE;
      exc_op_o = EXC_NONE;
    end
  end

  // decode owns four trap bits, everything else comes from fetch
  always_comb begin
    trap_bus_o               = trap_bus_i;
    trap_bus_o[TRAP_MRET]    = is_mret;
    trap_bus_o[TRAP_EBREAK]  = is_ebreak;
    trap_bus_o[TRAP_ECALL_M] = is_ecall;
    trap_bus_o[TRAP_ILLEGAL] = illegal;
  end

endmodule

//--- verilog/operand_forward.sv
`timescale 1ns/1ns

module operand_forward
  import decode_pkg::*;
(
  input  logic [REG_ADDR_W-1:0] idx_i,
  input  logic [XLEN-1:0]       gpr_data_i,
  input  logic [REG_ADDR_W-1:0] ex_rd_addr_i,
  input  logic [REG_ADDR_W-1:0] mem_rd_addr_i,
  input  logic [XLEN-1:0]       ex_rd_data_i,
  input  logic [XLEN-1:0]       mem_rd_data_i,
  output logic [XLEN-1:0]       data_o,
  output logic                  ex_match_o
);

  logic idx_nz;
  logic mem_match;

  // x0 is never forwarded
  assign idx_nz     = (idx_i != '0);
  assign ex_match_o = idx_nz && (idx_i == ex_rd_addr_i);
  assign mem_match  = idx_nz && (idx_i == mem_rd_addr_i);

  // youngest producer wins: execute, then memory, then register file
  assign data_o = ex_match_o ? ex_rd_data_i :
                  mem_match  ? mem_rd_data_i :
                               gpr_data_i;

endmodule
